// ==== source/nes_io_settings.svh ====
// widths of the host and memory buses
// autofire half period in clock cycles
// turbo button positions in the SNES-layout vector

`ifndef NES_IO_SETTINGS_SVH
`define NES_IO_SETTINGS_SVH

//////////////////////////////
// bus widths
`define RV_ADDR_W       23      // host byte address
`define RV_DATA_W       32      // host word
`define MEM_DATA_W      16      // memory half word

//////////////////////////////
// joypad
`define AUTOFIRE_HALF   6       // cycles per turbo phase
`define PAD_TURBO_A     8
`define PAD_TURBO_B     9

`endif

// ==== source/nes_io_pkg.sv ====
// vector types for the host bus, memory port and joypads
// state encoding of the memory bridge FSM

`include "nes_io_settings.svh"

package nes_io_pkg;

    // host side
    typedef logic [`RV_ADDR_W-1:0]      rv_addr_t;
    typedef logic [`RV_DATA_W-1:0]      rv_word_t;
    typedef logic [`RV_DATA_W/8-1:0]    rv_strb_t;   // one per byte

    // memory side
    typedef logic [`MEM_DATA_W-1:0]     mem_half_t;
    typedef logic [1:0]                 mem_ds_t;    // upper, lower byte enable

    // SNES layout with the NES buttons in the lower 8 bits
    // A B Select Start Up Down Left Right, turbo A, turbo B, L, R
    typedef logic [11:0]                snes_btns_t;
    typedef logic [7:0]                 nes_pad_t;

    // bridge FSM
    typedef enum logic [2:0] {
        IDLE_REQ0,      // wait for a request and issue the first half
        WAIT0_REQ1,     // wait for ack of the first half
        DATA0,          // lower read half is stable here
        WAIT1,          // wait for ack of the upper half
        DATA1           // read word complete
    } bridge_state_t;

endpackage

// ==== source/rv_mem_bridge.sv ====
// softcore memory bridge
// one 32-bit valid/ready request in, one or two 16-bit
// transfers out on a toggle req/ack port

`timescale 1ns/1ps
`include "nes_io_settings.svh"

module rv_mem_bridge
    import nes_io_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,

    // host side
    input  logic        i_rv_valid,
    input  rv_addr_t    i_rv_addr,
    input  rv_word_t    i_rv_wdata,
    input  rv_strb_t    i_rv_wstrb,
    output logic        o_rv_ready,
    output rv_word_t    o_rv_rdata,

    // memory side
    output logic        o_mem_req,
    input  logic        i_mem_ack,
    output rv_addr_t    o_mem_addr,
    output logic        o_mem_word,
    output logic        o_mem_we,
    output mem_ds_t     o_mem_ds,
    output mem_half_t   o_mem_wdata,
    input  mem_half_t   i_mem_rdata
);

    bridge_state_t  state;

    logic           rv_valid_q;     // for edge detect
    logic           req_pending;    // request seen while busy
    logic           mem_req;
    logic           mem_word;
    mem_ds_t        mem_ds;
    mem_half_t      rdata_lo;       // lower half of a read
    logic           ready;

    logic           valid_rise;
    logic           is_write;
    logic           acked;
    mem_ds_t        strb_lo;
    mem_ds_t        strb_hi;

    assign valid_rise = i_rv_valid & ~rv_valid_q;
    assign is_write   = |i_rv_wstrb;
    assign acked      = (mem_req == i_mem_ack);   // memory caught up with the toggle
    assign strb_lo    = i_rv_wstrb[1:0];
    assign strb_hi    = i_rv_wstrb[3:2];

    //////////////////////////////
    // request sequencing
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state       <= IDLE_REQ0;
            rv_valid_q  <= 1'b0;
            req_pending <= 1'b0;
            mem_req     <= 1'b0;
            ready       <= 1'b0;
        end else begin
            rv_valid_q <= i_rv_valid;
            ready      <= 1'b0;
            if (valid_rise)
                req_pending <= 1'b1;

            case (state)
                IDLE_REQ0: begin
                    if (req_pending || valid_rise) begin
                        req_pending <= 1'b0;
                        mem_req     <= ~mem_req;
                        if (is_write && strb_lo == 2'b00) begin
                            // upper half only
                            mem_word <= 1'b1;
                            mem_ds   <= strb_hi;
                            state    <= WAIT1;
                        end else begin
                            mem_word <= 1'b0;
                            mem_ds   <= is_write ? strb_lo : 2'b11;
                            state    <= WAIT0_REQ1;
                        end
                    end
                end

                WAIT0_REQ1: begin
                    if (acked) begin
                        if (!is_write) begin
                            state <= DATA0;
                        end else if (strb_hi == 2'b00) begin
                            // only the lower half was written
                            ready <= 1'b1;
                            state <= IDLE_REQ0;
                        end else begin
                            mem_req  <= ~mem_req;
                            mem_word <= 1'b1;
                            mem_ds   <= strb_hi;
                            state    <= WAIT1;
                        end
                    end
                end

                DATA0: begin
                    // grab the lower half before the next toggle
                    mem_req  <= ~mem_req;
                    mem_word <= 1'b1;
                    mem_ds   <= 2'b11;
                    state    <= WAIT1;
                end

                WAIT1: begin
                    if (acked) begin
                        if (is_write) begin
                            ready <= 1'b1;
                            state <= IDLE_REQ0;
                        end else begin
                            state <= DATA1;
                        end
                    end
                end

                DATA1: begin
                    ready <= 1'b1;      // upper half is live on i_mem_rdata
                    state <= IDLE_REQ0;
                end

                default: state <= IDLE_REQ0;
            endcase
        end
    end

    // lower read half captured in DATA0
    always_ff @(posedge clk) begin
        if (state == DATA0)
            rdata_lo <= i_mem_rdata;
    end

    //////////////////////////////
    // outputs
    assign o_rv_ready  = ready;
    assign o_rv_rdata  = {i_mem_rdata, rdata_lo};

    assign o_mem_req   = mem_req;
    assign o_mem_addr  = i_rv_addr;
    assign o_mem_word  = mem_word;
    assign o_mem_ds    = mem_ds;
    assign o_mem_we    = is_write;
    assign o_mem_wdata = mem_word ? i_rv_wdata[`RV_DATA_W-1 -: `MEM_DATA_W]
                                  : i_rv_wdata[`MEM_DATA_W-1:0];

endmodule

// ==== source/autofire.sv ====
// turbo square wave for one held button
// high phase first, then low, AUTOFIRE_HALF cycles each

`timescale 1ns/1ps
`include "nes_io_settings.svh"

module autofire
    import nes_io_pkg::*;
(
    input  logic    clk,
    input  logic    sys_resetn,
    input  logic    i_btn,
    output logic    o_fire
);

    localparam int CNT_W = $clog2(`AUTOFIRE_HALF + 1);

    logic [CNT_W-1:0]   phase_cnt;
    logic               phase_low;  // set during the low half

    always_ff @(posedge clk) begin
        if (!sys_resetn || !i_btn) begin
            // release restarts the wave
            phase_cnt <= '0;
            phase_low <= 1'b0;
        end else if (phase_cnt == CNT_W'(`AUTOFIRE_HALF - 1)) begin
            phase_cnt <= '0;
            phase_low <= ~phase_low;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    assign o_fire = i_btn & ~phase_low;

endmodule

// ==== source/joypad_port.sv ====
// NES joypad port for one pad
// button latch, serial shift register and turbo for A and B

`timescale 1ns/1ps
`include "nes_io_settings.svh"

module joypad_port
    import nes_io_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,
    input  snes_btns_t  i_btns,
    input  logic        i_strobe,
    input  logic        i_pad_clock,
    output logic        o_data
);

    nes_pad_t   pad_q;          // bit 0 goes out first
    nes_pad_t   load_val;
    logic       pad_clk_q;      // registered clock line
    logic       pad_clk_prev;
    logic       clk_fall;
    logic       fire_a;
    logic       fire_b;

    //////////////////////////////
    // turbo
    autofire af_a (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_btn      (i_btns[`PAD_TURBO_A]),
        .o_fire     (fire_a)
    );

    autofire af_b (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_btn      (i_btns[`PAD_TURBO_B]),
        .o_fire     (fire_b)
    );

    // NES buttons with autofire merged into B and A
    assign load_val = {i_btns[7:2], i_btns[1] | fire_b, i_btns[0] | fire_a};

    assign clk_fall = pad_clk_prev & ~pad_clk_q;

    //////////////////////////////
    // latch and shift
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pad_q        <= '1;         // idle pad reads as ones
            pad_clk_q    <= 1'b0;
            pad_clk_prev <= 1'b0;
        end else begin
            pad_clk_q    <= i_pad_clock;
            pad_clk_prev <= pad_clk_q;
            if (i_strobe)
                pad_q <= load_val;                  // reload every cycle while strobed
            else if (clk_fall)
                pad_q <= {1'b1, pad_q[7:1]};        // fill with ones
        end
    end

    assign o_data = pad_q[0];

endmodule

// ==== source/nes_io_top.sv ====
// top level of the NES I/O block
// softcore memory bridge and two joypad ports

`timescale 1ns/1ps

module nes_io_top
    import nes_io_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,

    // softcore host
    input  logic        i_rv_valid,
    input  rv_addr_t    i_rv_addr,
    input  rv_word_t    i_rv_wdata,
    input  rv_strb_t    i_rv_wstrb,
    output logic        o_rv_ready,
    output rv_word_t    o_rv_rdata,

    // memory port
    output logic        o_mem_req,
    input  logic        i_mem_ack,
    output rv_addr_t    o_mem_addr,
    output logic        o_mem_word,
    output logic        o_mem_we,
    output mem_ds_t     o_mem_ds,
    output mem_half_t   o_mem_wdata,
    input  mem_half_t   i_mem_rdata,

    // joypads
    input  snes_btns_t  i_joy1_btns,
    input  snes_btns_t  i_joy2_btns,
    input  logic        i_joy_strobe,   // shared by both pads
    input  logic [1:0]  i_joy_clock,
    output logic [1:0]  o_joy_data
);

    //////////////////////////////
    // memory bridge
    rv_mem_bridge u_bridge (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_rv_valid  (i_rv_valid),
        .i_rv_addr   (i_rv_addr),
        .i_rv_wdata  (i_rv_wdata),
        .i_rv_wstrb  (i_rv_wstrb),
        .o_rv_ready  (o_rv_ready),
        .o_rv_rdata  (o_rv_rdata),
        .o_mem_req   (o_mem_req),
        .i_mem_ack   (i_mem_ack),
        .o_mem_addr  (o_mem_addr),
        .o_mem_word  (o_mem_word),
        .o_mem_we    (o_mem_we),
        .o_mem_ds    (o_mem_ds),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata)
    );

    //////////////////////////////
    // joypad ports
    joypad_port u_pad1 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_btns      (i_joy1_btns),
        .i_strobe    (i_joy_strobe),
        .i_pad_clock (i_joy_clock[0]),
        .o_data      (o_joy_data[0])
    );

    joypad_port u_pad2 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_btns      (i_joy2_btns),
        .i_strobe    (i_joy_strobe),
        .i_pad_clock (i_joy_clock[1]),   // second pad
        .o_data      (o_joy_data[1])
    );

endmodule

// ==== dv/tb_mem_model.sv ====
// behavioral 16-bit memory on a toggle req/ack port
// random answer delay, masked writes, transfer counter

`timescale 1ns/1ps
`include "nes_io_settings.svh"

module tb_mem_model
    import nes_io_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,
    input  logic        i_mem_req,
    input  rv_addr_t    i_mem_addr,
    input  logic        i_mem_word,
    input  logic        i_mem_we,
    input  mem_ds_t     i_mem_ds,
    input  mem_half_t   i_mem_wdata,
    output logic        o_mem_ack,
    output mem_half_t   o_mem_rdata,
    output int          o_xfer_count
);

    localparam logic [31:0] SEED = 32'h2c5e6395;

    mem_half_t      mem_arr [int];      // sparse array indexed by {word address, half}
    logic [31:0]    rng_state;
    logic           busy;               // answer pending after a toggle
    int             delay;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // content of a location never written
    function automatic mem_half_t fill_half(input int idx);
        logic [31:0] h;
        h = idx * 32'h9e3779b1;
        return h[31:16] ^ h[15:0];
    endfunction

    always @(posedge clk) begin
        int         idx;
        mem_half_t  cur;
        if (!sys_resetn) begin
            o_mem_ack    <= 1'b0;
            o_mem_rdata  <= '0;
            o_xfer_count <= 0;
            busy         <= 1'b0;
            delay        <= 0;
            rng_state    <= SEED;
        end else if (!busy) begin
            if (i_mem_req != o_mem_ack) begin
                busy      <= 1'b1;
                rng_state <= xorshift32(rng_state);
                delay     <= xorshift32(rng_state) % 6;    // 0 to 5 cycles
            end
        end else if (delay != 0) begin
            delay <= delay - 1;
        end else begin
            idx = int'({i_mem_addr[`RV_ADDR_W-1:2], i_mem_word});
            cur = mem_arr.exists(idx) ? mem_arr[idx] : fill_half(idx);
            if (i_mem_we) begin
                if (i_mem_ds[1])
                    cur[15:8] = i_mem_wdata[15:8];
                if (i_mem_ds[0])
                    cur[7:0] = i_mem_wdata[7:0];
                mem_arr[idx] = cur;
            end else begin
                o_mem_rdata <= cur;     // held until the next toggle
            end
            o_mem_ack    <= i_mem_req;
            o_xfer_count <= o_xfer_count + 1;
            busy         <= 1'b0;
        end
    end

endmodule

// ==== dv/tb_nes_io_top.sv ====
// testbench for the NES I/O top level
// table of bus and joypad tests, shadow memory, compare tasks

`timescale 1ns/1ps
`include "nes_io_settings.svh"

module tb_nes_io_top
    import nes_io_pkg::*;
();

    localparam logic [31:0] SEED        = 32'h2c5e6395;
    localparam int          MEM_TIMEOUT = 200;     // cycles per request
    localparam int          RAND_OPS    = 8;

    typedef enum {OP_WRITE, OP_READ, OP_PAD, OP_TURBO} op_kind_t;

    typedef struct {
        op_kind_t   kind;
        rv_addr_t   addr;
        rv_word_t   data;       // pad 1 in [11:0] and pad 2 in [27:16] on pad tests
        rv_strb_t   strb;
        int         exp;        // transfers, or plain A after turbo release
    } stim_t;

    logic clk, sys_resetn;
    logic i_rv_valid, o_rv_ready, i_joy_strobe;
    rv_addr_t i_rv_addr, mem_addr;
    rv_word_t i_rv_wdata, o_rv_rdata;
    rv_strb_t i_rv_wstrb;
    logic mem_req, mem_ack, mem_word, mem_we;
    mem_ds_t mem_ds;
    mem_half_t mem_wdata, mem_rdata;
    snes_btns_t i_joy1_btns, i_joy2_btns;
    logic [1:0] i_joy_clock, o_joy_data;
    int xfer_count;

    stim_t      stim_q[$];
    rv_word_t   shadow [int];       // keyed by word address
    int         errors, pass_count, fail_count;
    bit         abort_run;

    nes_io_top dut (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr), .i_rv_wdata(i_rv_wdata),
        .i_rv_wstrb(i_rv_wstrb), .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata),
        .o_mem_req(mem_req), .i_mem_ack(mem_ack), .o_mem_addr(mem_addr),
        .o_mem_word(mem_word), .o_mem_we(mem_we), .o_mem_ds(mem_ds),
        .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata),
        .i_joy1_btns(i_joy1_btns), .i_joy2_btns(i_joy2_btns),
        .i_joy_strobe(i_joy_strobe), .i_joy_clock(i_joy_clock), .o_joy_data(o_joy_data)
    );

    tb_mem_model u_mem (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_mem_req(mem_req), .i_mem_addr(mem_addr), .i_mem_word(mem_word),
        .i_mem_we(mem_we), .i_mem_ds(mem_ds), .i_mem_wdata(mem_wdata),
        .o_mem_ack(mem_ack), .o_mem_rdata(mem_rdata), .o_xfer_count(xfer_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // compare tasks
    task automatic check_word(input string name, input rv_word_t exp, input rv_word_t act);
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reads take two transfers, writes one per nonzero strobe pair
    function automatic void push_mem(op_kind_t k, rv_addr_t a, rv_word_t d, rv_strb_t s);
        int n;
        n = (k == OP_READ) ? 2 : int'(|s[1:0]) + int'(|s[3:2]);
        stim_q.push_back('{k, a, d, (k == OP_READ) ? 4'h0 : s, n});
    endfunction

    function automatic void push_pad(op_kind_t k, rv_word_t d, int e);
        stim_q.push_back('{k, '0, d, 4'h0, e});
    endfunction

    function automatic void build_table();
        logic [31:0] rng;
        rv_addr_t    addrs[$];
        rng = SEED;
        push_mem(OP_WRITE, 23'h000100, 32'ha5a5_5a5a, 4'b1111);
        push_mem(OP_READ,  23'h000100, '0, '0);
        push_mem(OP_WRITE, 23'h000100, 32'h1234_5678, 4'b1100);
        push_mem(OP_READ,  23'h000100, '0, '0);
        push_mem(OP_WRITE, 23'h000100, 32'hdead_beef, 4'b0011);
        push_mem(OP_READ,  23'h000100, '0, '0);
        push_mem(OP_WRITE, 23'h7ffffc, 32'h0bad_f00d, 4'b1111);
        push_mem(OP_READ,  23'h7ffffc, '0, '0);
        // no turbo bits in these patterns
        push_pad(OP_PAD, {4'h0, 12'h83c, 4'h0, 12'h0a5}, 0);
        push_pad(OP_PAD, {4'h0, 12'h000, 4'h0, 12'h4ff}, 0);
        push_pad(OP_PAD, {4'h0, 12'h080, 4'h0, 12'h001}, 0);
        push_pad(OP_TURBO, 32'h0000_0100, 0);     // turbo A held, A released
        push_pad(OP_TURBO, 32'h0000_0100, 1);
        for (int i = 0; i < RAND_OPS; i++) begin
            rng = xorshift32(rng);
            addrs.push_back({rng[`RV_ADDR_W-1:2], 2'b00});
            rng = xorshift32(rng);
            push_mem(OP_WRITE, addrs[i], rng, 4'b1111);
        end
        foreach (addrs[i])
            push_mem(OP_READ, addrs[i], '0, '0);
    endfunction

    //////////////////////////////
    // test tasks
    task automatic run_mem_op(input stim_t e);
        int       start_cnt;
        int       cycles;
        bit       seen;
        rv_word_t got;
        int       key;
        @(negedge clk);
        start_cnt  = xfer_count;
        i_rv_valid = 1'b1;
        i_rv_addr  = e.addr;
        i_rv_wdata = e.data;
        i_rv_wstrb = e.strb;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < MEM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_rv_ready) begin
                seen = 1'b1;
                got  = o_rv_rdata;
            end
        end
        i_rv_valid = 1'b0;
        key = int'(e.addr[`RV_ADDR_W-1:2]);
        if (!seen) begin
            $display("timeout: o_rv_ready stayed low for %0d cycles at t=%0t", cycles, $time);
            errors++;
            abort_run = 1'b1;
        end else begin
            check_count("memory transfers", e.exp, xfer_count - start_cnt);
            if (e.kind == OP_WRITE) begin
                if (!shadow.exists(key))
                    shadow[key] = '0;
                for (int b = 0; b < 4; b++)
                    if (e.strb[b])
                        shadow[key][8*b +: 8] = e.data[8*b +: 8];
            end else if (!shadow.exists(key)) begin
                $display("read of an address the testbench never wrote at t=%0t", $time);
                errors++;
            end else begin
                check_word("o_rv_rdata", shadow[key], got);
            end
        end
    endtask

    // one pulse on both clock lines
    // the new bit is out 2 cycles after the fall
    task automatic pulse_pad_clocks();
        @(negedge clk);
        i_joy_clock = 2'b11;
        @(negedge clk);
        i_joy_clock = 2'b00;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_pad(input stim_t e);
        snes_btns_t b1;
        snes_btns_t b2;
        b1 = e.data[11:0];
        b2 = e.data[27:16];
        @(negedge clk);
        i_joy1_btns  = b1;
        i_joy2_btns  = b2;
        i_joy_strobe = 1'b1;
        @(negedge clk);
        i_joy_strobe = 1'b0;
        for (int i = 0; i < 11; i++) begin
            if (i > 0)
                pulse_pad_clocks();
            check_bit($sformatf("o_joy_data[0] bit %0d", i), (i < 8) ? b1[i] : 1'b1,
                      o_joy_data[0]);
            check_bit($sformatf("o_joy_data[1] bit %0d", i), (i < 8) ? b2[i] : 1'b1,
                      o_joy_data[1]);
        end
    endtask

    task automatic run_turbo(input stim_t e);
        bit         seen_hi;
        bit         seen_lo;
        snes_btns_t rel;
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        @(negedge clk);
        i_joy1_btns = e.data[11:0];
        i_joy2_btns = '0;
        repeat (4 * `AUTOFIRE_HALF) begin     // spans several turbo periods
            @(negedge clk);
            i_joy_strobe = 1'b1;
            @(negedge clk);
            i_joy_strobe = 1'b0;
            if (o_joy_data[0])
                seen_hi = 1'b1;
            else
                seen_lo = 1'b1;
        end
        check_bit("turbo A high phase seen", 1'b1, seen_hi);
        check_bit("turbo A low phase seen", 1'b1, seen_lo);
        rel = e.data[11:0];
        rel[`PAD_TURBO_A] = 1'b0;
        rel[0] = e.exp[0];
        @(negedge clk);
        i_joy1_btns  = rel;
        i_joy_strobe = 1'b1;
        @(negedge clk);
        i_joy_strobe = 1'b0;
        check_bit("o_joy_data[0] A after turbo release", e.exp[0], o_joy_data[0]);
    endtask

    task automatic log_test(input int n, input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("test %0d %s pass", n, name);
        end else begin
            fail_count++;
            $display("test %0d %s fail", n, name);
        end
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        int errs_before;
        sys_resetn   = 1'b0;
        i_rv_valid   = 1'b0;
        i_rv_addr    = '0;
        i_rv_wdata   = '0;
        i_rv_wstrb   = '0;
        i_joy1_btns  = '0;
        i_joy2_btns  = '0;
        i_joy_strobe = 1'b0;
        i_joy_clock  = 2'b00;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        abort_run    = 1'b0;
        build_table();

        repeat (8) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        errs_before = errors;
        check_bit("o_rv_ready", 1'b0, o_rv_ready);
        check_bit("o_mem_req", 1'b0, mem_req);
        check_bit("o_joy_data[0]", 1'b1, o_joy_data[0]);
        check_bit("o_joy_data[1]", 1'b1, o_joy_data[1]);
        log_test(0, "RESET", errs_before);

        for (int n = 0; n < stim_q.size() && !abort_run; n++) begin
            errs_before = errors;
            case (stim_q[n].kind)
                OP_PAD:   run_pad(stim_q[n]);
                OP_TURBO: run_turbo(stim_q[n]);
                default:  run_mem_op(stim_q[n]);
            endcase
            log_test(n + 1, stim_q[n].kind.name(), errs_before);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/nes_io_pkg.sv
source/rv_mem_bridge.sv
source/autofire.sv
source/joypad_port.sv
source/nes_io_top.sv
dv/tb_mem_model.sv
dv/tb_nes_io_top.sv
